// ==== Makefile ====
# Verilator build and run for the SPI memory peripheral

VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_spi_bus
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := Verification passed

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Runs from the project root so the input file path resolves
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/bus_bridge.sv ====
/*
  System side of the SPI bridge.
  Brings the command valid level across with two flops, detects its rise
  and performs one memory access for it. Writes strobe the memory once.
  Reads capture the registered memory data into rd_byte_o, which the
  SPI side sends as the first byte of the next transaction.
*/

`default_nettype none

module bus_bridge import spi_bus_pkg::*; #(
    parameter int ADDR_W = 12                 // Memory address width
) (
    input  wire logic              spi_cs_ni,   // System clock
    input  wire logic              spi_sck_i,   // System reset, active high
    input  wire spi_cmd_t          cmd_i,       // From the SPI domain, stable while valid
    input  wire logic              cmd_valid_i,
    output logic      [ADDR_W-1:0] ram_addr_o,
    output logic                   ram_we_o,
    output logic      [7:0]        ram_wdata_o,
    input  wire logic [7:0]        ram_rdata_i,
    output logic      [7:0]        rd_byte_o     // Read result for the next transaction
);

    logic valid_meta;  // First synchronizer stage
    logic valid_sync;
    logic valid_prev;  // For edge detection
    logic cmd_rise;    // One cycle at each new command
    logic rd_pend;     // Memory data for a read arrives this cycle

    always_ff @(posedge spi_cs_ni or posedge spi_sck_i) begin
        if (spi_sck_i) begin
            valid_meta <= 1'b0;
            valid_sync <= 1'b0;
            valid_prev <= 1'b0;
            rd_pend    <= 1'b0;
            rd_byte_o  <= 8'h00;
        end else begin
            valid_meta <= cmd_valid_i;
            valid_sync <= valid_meta;
            valid_prev <= valid_sync;
            rd_pend    <= cmd_rise & cmd_i.rd;  // Memory registers the read data first
            if (rd_pend) begin
                rd_byte_o <= ram_rdata_i;       // Held until the next read
            end
        end
    end

    assign cmd_rise = valid_sync & ~valid_prev;

    // Command is settled by the time the level has crossed over
    assign ram_addr_o  = cmd_i.addr[ADDR_W-1:0];  // Upper bits alias
    assign ram_wdata_o = cmd_i.data;
    assign ram_we_o    = cmd_rise & ~cmd_i.rd;

    // One strobe per transaction
    a_we_single : assert property (@(posedge spi_cs_ni) disable iff (spi_sck_i)
        ram_we_o |=> !ram_we_o)
        else $error("Write strobe held for two cycles");

endmodule

`default_nettype wire

// ==== design/byte_ram.sv ====
/*
  Single port byte memory in the system clock domain.
  Writes on the strobe and reads every cycle at the given address.
  Read data is registered and shows the old contents on a write cycle.
*/

`default_nettype none

module byte_ram #(
    parameter int ADDR_W = 12                 // 2^ADDR_W bytes
) (
    input  wire logic              spi_cs_ni,  // System clock
    input  wire logic [ADDR_W-1:0] addr_i,
    input  wire logic              we_i,       // Write strobe, one cycle
    input  wire logic [7:0]        wdata_i,
    output logic      [7:0]        rdata_o     // Valid the cycle after addr_i
);

    logic [7:0] mem [2**ADDR_W];  // Contents undefined after power up

    always_ff @(posedge spi_cs_ni) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
        rdata_o <= mem[addr_i];  // Read before write
    end

endmodule

`default_nettype wire

// ==== design/spi_bus_pkg.sv ====
/*
  Shared definitions for the SPI to memory bridge.
  Command byte bit positions, the protocol address width and the
  command struct passed from the SPI side decoder to the system side bridge.
  Modules take what they need through a wildcard import in their header.
*/

`default_nettype none

package spi_bus_pkg;

    // Protocol address is 17 bits wide, A16 travels in the command byte
    localparam int spi_addr_w = 17;

    // Command byte layout
    localparam int cmd_rd_bit   = 7;  // 1 = read, 0 = write
    localparam int cmd_addr_bit = 6;  // Two address bytes follow
    localparam int cmd_a16_bit  = 0;  // Address bit 16

    // Decoded command, held stable while the valid level is high
    typedef struct packed {
        logic                  rd;    // Direction of the access
        logic [spi_addr_w-1:0] addr;  // Full protocol address
        logic [7:0]            data;  // Write data, unused for reads
    } spi_cmd_t;

endpackage

`default_nettype wire

// ==== design/spi_bus_top.sv ====
/*
  Top level of the SPI memory peripheral.
  An external controller reaches the internal byte memory over SPI mode 0.
  The decoder runs on the serial pins, the bridge and memory run on the
  system clock. ADDR_W sets the memory size and is passed down.
*/

`default_nettype none

module spi_bus_top import spi_bus_pkg::*; #(
    parameter int ADDR_W = 12
) (
    input  wire logic spi_cs_ni,   // System clock
    input  wire logic spi_sck_i,   // System reset, active high
    input  wire logic ser_clk_i,   // Serial clock from the controller
    input  wire logic ser_sel_ni,  // Serial select, active low
    input  wire logic ser_pico_i,
    output logic      ser_poci_o
);

    spi_cmd_t          cmd;
    logic              cmd_valid;
    logic [7:0]        rd_byte;    // Returned in the next transaction
    logic [ADDR_W-1:0] ram_addr;
    logic              ram_we;
    logic [7:0]        ram_wdata;
    logic [7:0]        ram_rdata;

    // Serial clock domain
    spi_cmd_decoder u_decoder (
        .ser_clk_i   (ser_clk_i),
        .ser_sel_ni  (ser_sel_ni),
        .ser_pico_i  (ser_pico_i),
        .ser_poci_o  (ser_poci_o),
        .tx_byte_i   (rd_byte),
        .cmd_o       (cmd),
        .cmd_valid_o (cmd_valid)
    );

    // System clock domain
    bus_bridge #(
        .ADDR_W (ADDR_W)
    ) u_bridge (
        .spi_cs_ni   (spi_cs_ni),
        .spi_sck_i   (spi_sck_i),
        .cmd_i       (cmd),
        .cmd_valid_i (cmd_valid),
        .ram_addr_o  (ram_addr),
        .ram_we_o    (ram_we),
        .ram_wdata_o (ram_wdata),
        .ram_rdata_i (ram_rdata),
        .rd_byte_o   (rd_byte)
    );

    byte_ram #(
        .ADDR_W (ADDR_W)
    ) u_ram (
        .spi_cs_ni (spi_cs_ni),
        .addr_i    (ram_addr),
        .we_i      (ram_we),
        .wdata_i   (ram_wdata),
        .rdata_o   (ram_rdata)
    );

endmodule

`default_nettype wire

// ==== design/spi_byte.sv ====
/*
  SPI mode 0 byte shifter.
  Samples the incoming bit on the rising serial clock and drives the outgoing
  bit on the falling edge. Serial select high clears the bit counter.
  tx_byte_i is presented at select fall and reloaded at the start of each byte.
*/

`default_nettype none

module spi_byte (
    input  wire logic       ser_clk_i,   // Serial clock, idles low
    input  wire logic       ser_sel_ni,  // Select, high clears the shifter
    input  wire logic       ser_pico_i,
    output logic            ser_poci_o,
    input  wire logic [7:0] tx_byte_i,   // Byte to send, stable during a transaction
    output logic      [7:0] rx_byte_o,   // Received bits including the one on the line
    output logic            byte_end_o   // Last bit of a byte is on the line
);

    logic [2:0] bit_cnt;  // Bits already shifted in this byte
    logic [6:0] rx_q;     // Earlier bits of the current byte
    logic [7:0] tx_q;     // Bit 7 is on the line once shifting has started
    logic       tx_run;   // First falling edge seen

    // Bit counter, wraps every eight rising edges
    always_ff @(posedge ser_clk_i or posedge ser_sel_ni) begin
        if (ser_sel_ni) begin
            bit_cnt <= 3'd0;
        end else begin
            bit_cnt <= bit_cnt + 3'd1;
        end
    end

    always_ff @(posedge ser_clk_i) begin
        rx_q <= {rx_q[5:0], ser_pico_i};
    end

    // Newest bit taken straight from the pin so the byte is whole at the 8th rising edge
    assign rx_byte_o  = {rx_q, ser_pico_i};
    assign byte_end_o = (bit_cnt == 3'd7);

    always_ff @(negedge ser_clk_i or posedge ser_sel_ni) begin
        if (ser_sel_ni) begin
            tx_run <= 1'b0;
        end else begin
            tx_run <= 1'b1;
        end
    end

    always_ff @(negedge ser_clk_i) begin
        if (!tx_run) begin
            tx_q <= {tx_byte_i[6:0], 1'b0};  // MSB already went out since select fell
        end else if (bit_cnt == 3'd0) begin
            tx_q <= tx_byte_i;               // Falling edge that starts a new byte
        end else begin
            tx_q <= {tx_q[6:0], 1'b0};
        end
    end

    // Before the first falling edge the MSB comes straight from tx_byte_i
    assign ser_poci_o = tx_run ? tx_q[7] : tx_byte_i[7];

    // Mode 0 needs the clock idle low when a transaction opens
    a_sck_low_at_sel : assert property (@(negedge ser_sel_ni) !ser_clk_i)
        else $error("Serial clock high at select fall");

endmodule

`default_nettype wire

// ==== design/spi_cmd_decoder.sv ====
/*
  SPI command decoder.
  Steps a small FSM on every completed byte. Gathers direction, write data
  and address into a command struct and raises the valid level once the
  last argument byte is in. Select high returns the FSM to the command state.
  The address survives select so a command without one uses the last plus one.
*/

`default_nettype none

module spi_cmd_decoder import spi_bus_pkg::*; (
    input  wire logic       ser_clk_i,
    input  wire logic       ser_sel_ni,
    input  wire logic       ser_pico_i,
    output logic            ser_poci_o,
    input  wire logic [7:0] tx_byte_i,   // First byte returned to the controller
    output spi_cmd_t        cmd_o,       // Stable while cmd_valid_o is high
    output logic            cmd_valid_o  // Held until select rises
);

    // Bit 2 alone marks the valid state so the level never glitches
    typedef enum logic [2:0] {
        ST_CMD     = 3'b000,
        ST_DATA    = 3'b001,
        ST_ADDR_HI = 3'b010,
        ST_ADDR_LO = 3'b011,
        ST_VALID   = 3'b100
    } dec_state_e;

    dec_state_e state;
    dec_state_e state_d;

    logic [7:0] rx_byte;
    logic       byte_end;
    logic       addr_follows;  // Address bytes expected after the data byte
    logic       addr_a16;      // A16 from the command byte
    logic [7:0] addr_hi;       // Upper address byte awaiting the low byte

    spi_byte u_byte (
        .ser_clk_i  (ser_clk_i),
        .ser_sel_ni (ser_sel_ni),
        .ser_pico_i (ser_pico_i),
        .ser_poci_o (ser_poci_o),
        .tx_byte_i  (tx_byte_i),
        .rx_byte_o  (rx_byte),
        .byte_end_o (byte_end)
    );

    always_comb begin
        state_d = state;
        if (byte_end) begin
            case (state)
                ST_CMD: begin
                    casez ({rx_byte[cmd_rd_bit], rx_byte[cmd_addr_bit]})
                        2'b0?:   state_d = ST_DATA;     // Write, data byte next
                        2'b11:   state_d = ST_ADDR_HI;  // Read with address
                        default: state_d = ST_VALID;    // Read of next address
                    endcase
                end
                ST_DATA:    state_d = addr_follows ? ST_ADDR_HI : ST_VALID;
                ST_ADDR_HI: state_d = ST_ADDR_LO;
                ST_ADDR_LO: state_d = ST_VALID;
                default:    state_d = ST_VALID;  // Extra bytes are ignored
            endcase
        end
    end

    always_ff @(posedge ser_clk_i or posedge ser_sel_ni) begin
        if (ser_sel_ni) begin
            state <= ST_CMD;
        end else begin
            state <= state_d;
        end
    end

    assign cmd_valid_o = state[2];

    // Command fields. The address only changes on entry to valid,
    // so a transaction cut short leaves it alone
    always_ff @(posedge ser_clk_i) begin
        if (byte_end) begin
            case (state)
                ST_CMD: begin
                    cmd_o.rd     <= rx_byte[cmd_rd_bit];
                    addr_follows <= rx_byte[cmd_addr_bit];
                    addr_a16     <= rx_byte[cmd_a16_bit];
                    if (rx_byte[cmd_rd_bit] && !rx_byte[cmd_addr_bit]) begin
                        cmd_o.addr <= cmd_o.addr + spi_addr_w'(1);
                    end
                end
                ST_DATA: begin
                    cmd_o.data <= rx_byte;
                    if (!addr_follows) begin
                        cmd_o.addr <= cmd_o.addr + spi_addr_w'(1);  // Wraps at 2^17
                    end
                end
                ST_ADDR_HI: addr_hi <= rx_byte;
                ST_ADDR_LO: cmd_o.addr <= {addr_a16, addr_hi, rx_byte};
                default: ;
            endcase
        end
    end

    // The bridge samples cmd_o at an unrelated time after the valid level crosses over
    a_cmd_stable : assert property (@(posedge ser_clk_i) disable iff (ser_sel_ni)
        cmd_valid_o |=> $stable(cmd_o))
        else $error("Command changed while valid");

endmodule

`default_nettype wire

// ==== dv/spi_bus_input.txt ====
# op cmd nargs arg0 arg1 arg2 chk exp  (bytes hex, nargs and chk decimal)
# op W write, R read, C cut after the listed bytes; exp is the first byte returned
W 40 3 a5 01 23 1 00
R c0 2 01 23 00 1 00
W 40 3 3c 02 00 1 a5
W 00 1 11 00 00 1 a5
W 00 1 22 00 00 1 a5
W 00 1 33 00 00 1 a5
R c0 2 02 01 00 1 a5
R 80 0 00 00 00 1 11
R 80 0 00 00 00 1 22
W 40 3 5a 03 45 1 33
R c0 2 13 45 00 1 33
R c0 2 01 23 00 1 5a
R c1 2 03 45 00 1 a5
W 41 3 c3 f6 78 1 5a
R c0 2 06 78 00 1 5a
R c0 2 01 23 00 1 c3
C 40 0 00 00 00 1 a5
C 00 0 00 00 00 1 a5
R c0 2 02 00 00 1 a5
R c0 2 01 23 00 1 3c
R c0 2 02 02 00 1 a5
R be 1 5a 00 00 1 22
W 00 1 44 00 00 1 33
R c0 2 02 03 00 1 33
R 81 0 00 00 00 1 33
W 40 3 99 0f ff 1 44
W 00 1 77 00 00 1 44
R c0 2 00 00 00 1 44
W 00 1 00 00 00 1 77

// ==== dv/tb_spi_bus.sv ====
/*
  Testbench for the SPI memory peripheral.
  Reads transactions from dv/spi_bus_input.txt, plays each one as an SPI
  mode 0 transfer and checks the first byte the DUT returns against the
  expected value from the file. Run from the project root.
*/

`default_nettype none

module tb_spi_bus;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period  = 40;
    localparam int half_cycles = 5;    // 200 ns serial half period
    localparam int gap_cycles  = 10;   // Select high after each transaction
    localparam int drive_dly   = 2;    // Input skew after the system clock edge
    localparam int txn_budget  = 400;  // Cycles per transaction, worst case is 4 bytes

    // One line of the input file
    typedef struct packed {
        logic [7:0]      op;     // W, R or C
        logic [7:0]      cmd;
        logic [1:0]      nargs;  // Argument bytes after the command
        logic [2:0][7:0] args;   // args[0] goes out first
        logic            chk;    // Compare the first returned byte
        logic [7:0]      exp;
    } txn_t;

    logic spi_cs_ni;
    logic spi_sck_i;
    logic ser_clk_i;
    logic ser_sel_ni;
    logic ser_pico_i;
    logic ser_poci_o;

    txn_t txn_q[$];
    int   cycle_cnt   = 0;
    int   cycle_limit = 0;  // Zero until the input file is read

    spi_bus_top #(
        .ADDR_W (12)
    ) dut (
        .spi_cs_ni  (spi_cs_ni),
        .spi_sck_i  (spi_sck_i),
        .ser_clk_i  (ser_clk_i),
        .ser_sel_ni (ser_sel_ni),
        .ser_pico_i (ser_pico_i),
        .ser_poci_o (ser_poci_o)
    );

    always #(clk_period / 2) spi_cs_ni = ~spi_cs_ni;

    // Watchdog on the system clock
    always @(posedge spi_cs_ni) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Run timed out after %0d system clocks", cycle_cnt);
            $display("Verification failed");
            $fatal(1, "Timeout");
        end
    end

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1, "Stopped at %0t ns", $time);
    endtask

    // Returns a few ns after the n-th rising system edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge spi_cs_ni);
        #drive_dly;
    endtask

    task automatic load_transactions();
        int         fd;
        int         n;
        int         line_no;
        int         n_args;
        int         chk_v;
        string      line;
        logic [7:0] op_c;
        logic [7:0] cmd_v;
        logic [7:0] exp_v;
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] a2;
        txn_t       t;
        fd = $fopen("dv/spi_bus_input.txt", "r");
        assert (fd != 0) else begin
            $display("Cannot open dv/spi_bus_input.txt for reading");
            abort_run();
        end
        line_no = 0;
        while ($fgets(line, fd) > 0) begin
            line_no++;
            if (line.len() < 2 || line[0] == "#") continue;  // Blank or column notes
            n = $sscanf(line, "%c %h %d %h %h %h %d %h",
                        op_c, cmd_v, n_args, a0, a1, a2, chk_v, exp_v);
            assert (n == 8 && n_args >= 0 && n_args <= 3) else begin
                $display("Line %0d of the input file cannot be parsed", line_no);
                abort_run();
            end
            t.op    = op_c;
            t.cmd   = cmd_v;
            t.nargs = n_args[1:0];
            t.args  = {a2, a1, a0};
            t.chk   = chk_v[0];
            t.exp   = exp_v;
            txn_q.push_back(t);
        end
        $fclose(fd);
    endtask

    // MSB first, controller side of mode 0
    task automatic shift_byte(input logic [7:0] tx, output logic [7:0] rx);
        rx = 8'h00;
        for (int i = 7; i >= 0; i--) begin
            ser_pico_i = tx[i];  // Set up while the serial clock is low
            wait_cycles(half_cycles);
            rx = {rx[6:0], ser_poci_o};  // Sampled at the rising edge
            ser_clk_i = 1'b1;
            wait_cycles(half_cycles);
            ser_clk_i = 1'b0;
        end
    endtask

    task automatic play_transaction(input txn_t t, input int idx);
        logic [7:0] first_rx;
        logic [7:0] rx;
        int         gap;
        ser_sel_ni = 1'b0;
        shift_byte(t.cmd, first_rx);  // Returns the previous read result
        for (int i = 0; i < int'(t.nargs); i++) begin
            shift_byte(t.args[i], rx);
        end
        wait_cycles(half_cycles);
        ser_sel_ni = 1'b1;  // Cut transactions end here after the command byte
        if (t.chk) begin
            assert (first_rx === t.exp) else begin
                $display("Error at %0t ns: ser_poci_o txn %0d (%c) is %02h, expected %02h",
                         $time, idx, t.op, first_rx, t.exp);
                abort_run();
            end
        end
        gap = gap_cycles + int'($urandom % 6);  // Bridge needs 8 clocks at least
        wait_cycles(gap);
    endtask

    initial begin
        spi_cs_ni  = 1'b0;
        spi_sck_i  = 1'b1;  // Reset from time zero
        ser_clk_i  = 1'b0;  // Mode 0 idle level
        ser_sel_ni = 1'b1;
        ser_pico_i = 1'b0;
        void'($urandom(32'h46c1285a));
        load_transactions();
        assert (txn_q.size() > 0) else begin
            $display("The input file holds no transactions");
            abort_run();
        end
        cycle_limit = (txn_q.size() + 1) * txn_budget;
        wait_cycles(2);
        spi_sck_i = 1'b0;
        wait_cycles(gap_cycles);
        foreach (txn_q[i]) begin
            play_transaction(txn_q[i], i);
        end
        $display("%0d transactions checked", txn_q.size());
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/spi_bus_pkg.sv
design/spi_byte.sv
design/spi_cmd_decoder.sv
design/bus_bridge.sv
design/byte_ram.sv
design/spi_bus_top.sv
dv/tb_spi_bus.sv
